//--- tests/memStimulus.txt
# op addr len wrData expected   (op: F fetch, L load, S store, B fetch and load together)
# for B lines the wrData column holds the expected fetch word
S 0100 4 12345678 00000000
L 0100 4 00000000 12345678
F 0100 4 00000000 12345678
S 0104 2 0000beef 00000000
L 0104 2 00000000 0000beef
S 0106 1 000000a5 00000000
L 0106 1 00000000 000000a5
S 0107 1 ffffff3c 00000000
L 0104 4 00000000 3ca5beef
F 0104 4 00000000 3ca5beef
S 0101 1 000000cc 00000000
L 0100 4 00000000 1234cc78
L 0100 2 00000000 0000cc78
L 0102 2 00000000 00001234
L 0103 1 00000000 00000012
F 0102 4 00000000 beef1234
S 0200 4 cafef00d 00000000
S 0202 2 ffff1a2b 00000000
B 0200 4 1a2bf00d 1a2bf00d
B 0104 2 3ca5beef 0000beef
S 0300 4 01020304 00000000
S 0301 2 0000aabb 00000000
L 0300 4 00000000 01aabb04
L 0301 2 00000000 0000aabb
F 0300 4 00000000 01aabb04

//--- filelist.f
hdl/memPkg.sv
hdl/memAccessIf.sv
hdl/ramBusIf.sv
hdl/byteRam.sv
hdl/instFetchPort.sv
hdl/dataAccessPort.sv
hdl/memArbiter.sv
hdl/memSubsystem.sv
tests/memSubsystem_asserts.sv
tests/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build and run the memSubsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module memSubsystemTb \
    -f filelist.f \
    -o memSubsystemSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memSubsystemSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

//--- tests/memSubsystemTb.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystemTb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int CYCLES_PER_LINE = 40;
    localparam int PASSES          = 2;

    logic         clk;
    logic         rst;
    logic         i_ioFull;
    logic         i_fetchReq;
    memPkg::addrT i_fetchAddr;
    logic         o_fetchAck;
    memPkg::wordT o_fetchInst;
    logic         i_dataReq;
    logic         i_dataWrite;
    memPkg::lenT  i_dataLen;
    memPkg::addrT i_dataAddr;
    memPkg::wordT i_dataWrData;
    logic         o_dataAck;
    memPkg::wordT o_dataRdData;

    // one entry per stimulus line
    logic [7:0]   opList [$];
    memPkg::addrT addrList [$];
    memPkg::lenT  lenList [$];
    memPkg::wordT wrList [$];
    memPkg::wordT expList [$];

    integer seed;
    logic   stallEn;
    logic   stimLoaded;
    logic   prevDataAck;
    logic   prevFetchAck;
    logic   prevIoFull;

    memSubsystem #(
        .ADDR_W    (memPkg::ADDR_W),
        .RAM_DEPTH (2 ** memPkg::ADDR_W)
    ) memSubsystem_inst (
        .clk          (clk),
        .rst          (rst),
        .i_ioFull     (i_ioFull),
        .i_fetchReq   (i_fetchReq),
        .i_fetchAddr  (i_fetchAddr),
        .o_fetchAck   (o_fetchAck),
        .o_fetchInst  (o_fetchInst),
        .i_dataReq    (i_dataReq),
        .i_dataWrite  (i_dataWrite),
        .i_dataLen    (i_dataLen),
        .i_dataAddr   (i_dataAddr),
        .i_dataWrData (i_dataWrData),
        .o_dataAck    (o_dataAck),
        .o_dataRdData (o_dataRdData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkEqual(input memPkg::wordT actual, input memPkg::wordT expected,
                              input string what);
        if (actual !== expected) begin
            stopOnError($sformatf("Fail at %0t: %s, got %h, expected %h",
                                  $time, what, actual, expected));
        end
    endtask

    task automatic nextCycle;
        @(posedge clk);
        #2;
    endtask

    task automatic loadStimulus;
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] len;
        logic [31:0] wr;
        logic [31:0] expected;
        fd = $fopen("tests/memStimulus.txt", "r");
        if (fd == 0) begin
            stopOnError("Could not open the stimulus file tests/memStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                // skip comments and blank lines
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%c %h %h %h %h", op, addr, len, wr, expected);
                    if (fields != 5) begin
                        stopOnError($sformatf("Stimulus line could not be parsed: %s", line));
                    end else begin
                        opList.push_back(op);
                        addrList.push_back(addr[memPkg::ADDR_W-1:0]);
                        lenList.push_back(len[2:0]);
                        wrList.push_back(wr);
                        expList.push_back(expected);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic fetchWord(input memPkg::addrT addr, input memPkg::wordT expected);
        i_fetchAddr = addr;
        i_fetchReq  = 1'b1;
        while (!o_fetchAck) nextCycle();
        checkEqual(o_fetchInst, expected, $sformatf("fetch at %h", addr));
        i_fetchReq = 1'b0;
        while (o_fetchAck) nextCycle();
    endtask

    task automatic dataAccess(input logic write, input memPkg::lenT len,
                              input memPkg::addrT addr, input memPkg::wordT wrData,
                              input memPkg::wordT expected);
        string what;
        if (write) begin
            what = $sformatf("store at %h", addr);
        end else begin
            what = $sformatf("load at %h", addr);
        end
        i_dataWrite  = write;
        i_dataLen    = len;
        i_dataAddr   = addr;
        i_dataWrData = wrData;
        i_dataReq    = 1'b1;
        while (!o_dataAck) nextCycle();
        // a store hands back zero
        checkEqual(o_dataRdData, expected, what);
        i_dataReq = 1'b0;
        while (o_dataAck) nextCycle();
    endtask

    // both requests in one cycle, data side must finish first
    task automatic fetchAndLoad(input memPkg::addrT addr, input memPkg::lenT len,
                                input memPkg::wordT fetchExp, input memPkg::wordT loadExp);
        i_fetchAddr  = addr;
        i_dataWrite  = 1'b0;
        i_dataLen    = len;
        i_dataAddr   = addr;
        i_dataWrData = '0;
        i_fetchReq   = 1'b1;
        i_dataReq    = 1'b1;
        while (!o_dataAck && !o_fetchAck) nextCycle();
        checkEqual({31'd0, o_fetchAck}, 32'd0, "fetch ack came before data ack");
        checkEqual(o_dataRdData, loadExp, $sformatf("concurrent load at %h", addr));
        i_dataReq = 1'b0;
        while (!o_fetchAck) nextCycle();
        checkEqual(o_fetchInst, fetchExp, $sformatf("concurrent fetch at %h", addr));
        i_fetchReq = 1'b0;
        while (o_fetchAck) nextCycle();
    endtask

    // random stall pulses
    initial begin
        i_ioFull = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            i_ioFull = stallEn && (($random(seed) & 3) == 0);
        end
    end

    // an ack edge must not follow a cycle with the stall high
    always @(negedge clk) begin
        if (rst) begin
            prevDataAck  = 1'b0;
            prevFetchAck = 1'b0;
            prevIoFull   = 1'b0;
        end else begin
            if (prevIoFull) begin
                checkEqual({31'd0, o_dataAck && !prevDataAck}, 32'd0,
                           "data ack rose during stall");
                checkEqual({31'd0, o_fetchAck && !prevFetchAck}, 32'd0,
                           "fetch ack rose during stall");
            end
            prevDataAck  = o_dataAck;
            prevFetchAck = o_fetchAck;
            prevIoFull   = i_ioFull;
        end
    end

    initial begin
        int limitCycles;
        wait (stimLoaded === 1'b1);
        limitCycles = CYCLES_PER_LINE * opList.size() * PASSES + RESET_CYCLES + 100;
        repeat (limitCycles) @(posedge clk);
        stopOnError($sformatf("Timeout: the run did not finish within %0d cycles",
                              limitCycles));
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        seed         = 32'h5ff2b18e;
        stallEn      = 1'b0;
        stimLoaded   = 1'b0;
        i_fetchReq   = 1'b0;
        i_fetchAddr  = '0;
        i_dataReq    = 1'b0;
        i_dataWrite  = 1'b0;
        i_dataLen    = memPkg::LEN_WORD;
        i_dataAddr   = '0;
        i_dataWrData = '0;
        loadStimulus();
        stimLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (2) nextCycle();
        checkEqual({30'd0, o_fetchAck, o_dataAck}, 32'd0, "acks idle after reset");
        // second pass repeats the list with stalls
        for (int pass = 0; pass < PASSES; pass++) begin
            stallEn = (pass == 1);
            for (int i = 0; i < opList.size(); i++) begin
                case (opList[i])
                    "F": fetchWord(addrList[i], expList[i]);
                    "L": dataAccess(1'b0, lenList[i], addrList[i], wrList[i], expList[i]);
                    "S": dataAccess(1'b1, lenList[i], addrList[i], wrList[i], expList[i]);
                    "B": fetchAndLoad(addrList[i], lenList[i], wrList[i], expList[i]);
                    default: stopOnError($sformatf("Unknown operation code on line %0d", i));
                endcase
            end
        end
        stallEn = 1'b0;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/memSubsystem_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystemAsserts (
    input wire clk,
    input wire rst,
    input wire i_ioFull,
    input wire i_fetchReq,
    input wire i_dataReq,
    input wire i_fetchAck,
    input wire i_dataAck
);

    // ack edge follows a cycle with req high
    fetchAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(i_fetchAck) |-> $past(i_fetchReq)) else $error("fetch ack rose without req");
    dataAckNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(i_dataAck) |-> $past(i_dataReq)) else $error("data ack rose without req");

    fetchAckHeld: assert property (@(posedge clk) disable iff (rst)
        i_fetchAck && i_fetchReq |=> i_fetchAck) else $error("fetch ack dropped early");
    dataAckHeld: assert property (@(posedge clk) disable iff (rst)
        i_dataAck && i_dataReq |=> i_dataAck) else $error("data ack dropped early");

    // a stalled edge leaves both acks where they were
    stallHoldsAcks: assert property (@(posedge clk) disable iff (rst)
        i_ioFull |=> $stable(i_fetchAck) && $stable(i_dataAck))
        else $error("ack changed during stall");

    acksExclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchAck && i_dataAck)) else $error("both acks high");

endmodule

bind memSubsystem memSubsystemAsserts memSubsystemAsserts_inst (
    .clk        (clk),
    .rst        (rst),
    .i_ioFull   (i_ioFull),
    .i_fetchReq (fetchAcc.req),
    .i_dataReq  (dataAcc.req),
    .i_fetchAck (fetchAcc.ack),
    .i_dataAck  (dataAcc.ack)
);

`default_nettype wire

//--- hdl/memSubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module memSubsystem #(
    parameter int ADDR_W    = memPkg::ADDR_W,
    parameter int RAM_DEPTH = 2 ** ADDR_W
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           i_ioFull,
    input  wire           i_fetchReq,
    input  memPkg::addrT  i_fetchAddr,
    output logic          o_fetchAck,
    output memPkg::wordT  o_fetchInst,
    input  wire           i_dataReq,
    input  wire           i_dataWrite,
    input  memPkg::lenT   i_dataLen,
    input  memPkg::addrT  i_dataAddr,
    input  memPkg::wordT  i_dataWrData,
    output logic          o_dataAck,
    output memPkg::wordT  o_dataRdData
);

    memAccessIf #(.ADDR_W(ADDR_W)) fetchAcc ();
    memAccessIf #(.ADDR_W(ADDR_W)) dataAcc ();
    ramBusIf #(.ADDR_W(ADDR_W)) ramBus ();

    instFetchPort instFetchPort_inst (
        .clk    (clk),
        .rst    (rst),
        .i_req  (i_fetchReq),
        .i_addr (i_fetchAddr),
        .o_ack  (o_fetchAck),
        .o_inst (o_fetchInst),
        .acc    (fetchAcc.requester)
    );

    dataAccessPort dataAccessPort_inst (
        .clk      (clk),
        .rst      (rst),
        .i_req    (i_dataReq),
        .i_write  (i_dataWrite),
        .i_len    (i_dataLen),
        .i_addr   (i_dataAddr),
        .i_wrData (i_dataWrData),
        .o_ack    (o_dataAck),
        .o_rdData (o_dataRdData),
        .acc      (dataAcc.requester)
    );

    memArbiter #(.ADDR_W(ADDR_W)) memArbiter_inst (
        .clk      (clk),
        .rst      (rst),
        .i_ioFull (i_ioFull),
        .dataAcc  (dataAcc.arbiter),
        .fetchAcc (fetchAcc.arbiter),
        .ram      (ramBus.master)
    );

    byteRam #(
        .ADDR_W    (ADDR_W),
        .RAM_DEPTH (RAM_DEPTH)
    ) byteRam_inst (
        .clk (clk),
        .bus (ramBus.ram)
    );

endmodule

`default_nettype wire

//--- hdl/memArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module memArbiter #(
    parameter int ADDR_W = memPkg::ADDR_W
) (
    input wire           clk,
    input wire           rst,
    input wire           i_ioFull,
    memAccessIf.arbiter  dataAcc,
    memAccessIf.arbiter  fetchAcc,
    ramBusIf.master      ram
);

    memPkg::arbStateT  state;
    memPkg::ownerT     owner;
    memPkg::lenT       stage;
    memPkg::wordT      word;
    logic              dataAckQ;
    logic              fetchAckQ;

    logic              curReq;
    logic [ADDR_W-1:0] curAddr;
    memPkg::lenT       curLen;
    logic              curWrite;
    memPkg::wordT      curWrData;
    logic              active;
    logic              lastStage;
    logic [1:0]        capIdx;

    // fields of whichever port holds the bus
    always_comb begin
        if (owner == memPkg::OWN_DATA) begin
            curReq    = dataAcc.req;
            curAddr   = dataAcc.addr;
            curLen    = dataAcc.len;
            curWrite  = dataAcc.write;
            curWrData = dataAcc.wrData;
        end else begin
            curReq    = fetchAcc.req;
            curAddr   = fetchAcc.addr;
            curLen    = fetchAcc.len;
            curWrite  = fetchAcc.write;
            curWrData = fetchAcc.wrData;
        end
    end

    assign active = (state == memPkg::GRANT) || (state == memPkg::XFER);

    // reads need one extra stage to capture the last byte
    assign lastStage = curWrite ? (stage == memPkg::lenT'(curLen - 3'd1))
                                : (stage == curLen);

    // byte read back in this stage was addressed one stage earlier
    assign capIdx = stage[1:0] - 2'd1;

    // while stalled, keep presenting the previous address so the RAM output
    // still holds the byte the next stage captures
    assign ram.addr   = curAddr + ADDR_W'(stage) - ADDR_W'(i_ioFull);
    assign ram.we     = active && curWrite && !i_ioFull;
    assign ram.wrData = curWrData[{stage[1:0], 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= memPkg::IDLE;
            owner     <= memPkg::OWN_DATA;
            stage     <= '0;
            dataAckQ  <= 1'b0;
            fetchAckQ <= 1'b0;
        end else if (!i_ioFull) begin
            case (state)
                memPkg::IDLE: begin
                    stage <= '0;
                    // data side has priority
                    if (dataAcc.req) begin
                        owner <= memPkg::OWN_DATA;
                        state <= memPkg::GRANT;
                    end else if (fetchAcc.req) begin
                        owner <= memPkg::OWN_FETCH;
                        state <= memPkg::GRANT;
                    end
                end
                memPkg::GRANT, memPkg::XFER: begin
                    stage <= stage + 3'd1;
                    state <= lastStage ? memPkg::DONE : memPkg::XFER;
                end
                memPkg::DONE: begin
                    if (!curReq) begin
                        dataAckQ  <= 1'b0;
                        fetchAckQ <= 1'b0;
                        state     <= memPkg::IDLE;
                    end else if (owner == memPkg::OWN_DATA) begin
                        dataAckQ <= 1'b1;
                    end else begin
                        fetchAckQ <= 1'b1;
                    end
                end
                default: state <= memPkg::IDLE;
            endcase
        end
    end

    // little-endian assembly, byte k lands in word[8k +: 8]
    always_ff @(posedge clk) begin
        if (!i_ioFull && active && !curWrite && stage != '0) begin
            word[{capIdx, 3'b000} +: 8] <= ram.rdData;
        end
    end

    assign dataAcc.ack     = dataAckQ;
    assign fetchAcc.ack    = fetchAckQ;
    assign dataAcc.rdData  = word;
    assign fetchAcc.rdData = word;

endmodule

`default_nettype wire

//--- hdl/dataAccessPort.sv
`timescale 1ns/100ps
`default_nettype none

module dataAccessPort (
    input  wire            clk,
    input  wire            rst,
    input  wire            i_req,
    input  wire            i_write,
    input  memPkg::lenT    i_len,
    input  memPkg::addrT   i_addr,
    input  memPkg::wordT   i_wrData,
    output logic           o_ack,
    output memPkg::wordT   o_rdData,
    memAccessIf.requester  acc
);

    logic         reqQ;
    logic         writeQ;
    memPkg::lenT  lenQ;
    memPkg::addrT addrQ;
    memPkg::wordT wrDataQ;
    memPkg::wordT rdDataQ;
    memPkg::wordT lenMask;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqQ <= 1'b0;
        end else begin
            reqQ <= i_req;
        end
    end

    // operation latched on the rising req
    always_ff @(posedge clk) begin
        if (i_req && !reqQ) begin
            writeQ  <= i_write;
            lenQ    <= i_len;
            addrQ   <= i_addr;
            wrDataQ <= i_wrData;
        end
    end

    // bytes above the length read as zero
    always_comb begin
        case (lenQ)
            memPkg::LEN_BYTE: lenMask = 32'h0000_00ff;
            memPkg::LEN_HALF: lenMask = 32'h0000_ffff;
            default:          lenMask = 32'hffff_ffff;
        endcase
    end

    // a store hands back zero
    always_ff @(posedge clk) begin
        if (acc.req && !acc.ack) begin
            rdDataQ <= writeQ ? '0 : (acc.rdData & lenMask);
        end
    end

    assign acc.req    = i_req;
    assign acc.addr   = addrQ;
    assign acc.len    = lenQ;
    assign acc.write  = writeQ;
    assign acc.wrData = wrDataQ;

    assign o_ack    = acc.ack;
    assign o_rdData = rdDataQ;

endmodule

`default_nettype wire

//--- hdl/instFetchPort.sv
`timescale 1ns/100ps
`default_nettype none

module instFetchPort (
    input  wire            clk,
    input  wire            rst,
    input  wire            i_req,
    input  memPkg::addrT   i_addr,
    output logic           o_ack,
    output memPkg::wordT   o_inst,
    memAccessIf.requester  acc
);

    logic         reqQ;
    memPkg::addrT addrQ;
    memPkg::wordT instQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqQ <= 1'b0;
        end else begin
            reqQ <= i_req;
        end
    end

    // address held from the rising req until the next one
    always_ff @(posedge clk) begin
        if (i_req && !reqQ) begin
            addrQ <= i_addr;
        end
    end

    // last sample lands on the edge where ack rises, word is final by then
    always_ff @(posedge clk) begin
        if (acc.req && !acc.ack) begin
            instQ <= acc.rdData;
        end
    end

    assign acc.req    = i_req;
    assign acc.addr   = addrQ;
    assign acc.len    = memPkg::LEN_WORD;
    assign acc.write  = 1'b0;
    assign acc.wrData = '0;

    assign o_ack  = acc.ack;
    assign o_inst = instQ;

endmodule

`default_nettype wire

//--- hdl/byteRam.sv
`timescale 1ns/100ps
`default_nettype none

module byteRam #(
    parameter int ADDR_W    = memPkg::ADDR_W,
    parameter int RAM_DEPTH = 2 ** ADDR_W
) (
    input wire    clk,
    ramBusIf.ram  bus
);

    memPkg::byteT mem [RAM_DEPTH];
    memPkg::byteT rdQ;

    // a read of the address being written returns the old byte
    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.wrData;
        end
    end

    always_ff @(posedge clk) begin
        rdQ <= mem[bus.addr];
    end

    assign bus.rdData = rdQ;

endmodule

`default_nettype wire

//--- hdl/ramBusIf.sv
`timescale 1ns/100ps
`default_nettype none

interface ramBusIf #(
    parameter int ADDR_W = memPkg::ADDR_W
);
    logic [ADDR_W-1:0] addr;
    logic              we;
    memPkg::byteT      wrData;
    // valid one cycle after a read address
    memPkg::byteT      rdData;

    modport master (output addr, we, wrData, input rdData);
    modport ram (input addr, we, wrData, output rdData);
endinterface

`default_nettype wire

//--- hdl/memAccessIf.sv
`timescale 1ns/100ps
`default_nettype none

interface memAccessIf #(
    parameter int ADDR_W = memPkg::ADDR_W
);
    logic              req;
    logic              ack;
    logic [ADDR_W-1:0] addr;
    memPkg::lenT       len;
    logic              write;
    memPkg::wordT      wrData;
    memPkg::wordT      rdData;

    modport requester (output req, addr, len, write, wrData, input ack, rdData);
    modport arbiter (input req, addr, len, write, wrData, output ack, rdData);
endinterface

`default_nettype wire

//--- hdl/memPkg.sv
`default_nettype none

package memPkg;

    // must agree with ADDR_W at the top level
    localparam int ADDR_W = 16;

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [31:0]       wordT;
    typedef logic [7:0]        byteT;

    // byte count of one access, only 1, 2 and 4 are legal
    typedef logic [2:0] lenT;

    localparam lenT LEN_BYTE = 3'd1;
    localparam lenT LEN_HALF = 3'd2;
    localparam lenT LEN_WORD = 3'd4;

    typedef enum logic [1:0] {
        IDLE,
        GRANT,
        XFER,
        DONE
    } arbStateT;

    typedef enum logic {
        OWN_DATA,
        OWN_FETCH
    } ownerT;

endpackage

`default_nettype wire
